//--- id_stage.f
+incdir+.
id_pkg.sv
id_decoder.sv
id_operand_mux.sv
id_ex_fsm.sv
id_stage.sv
tb_id_stage.sv

//--- Makefile
TOOL       := verilator
TOP        := tb_id_stage
FILELIST   := id_stage.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Test failed
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_id_stage.sv
// Directed testbench for the decode stage
// Drives RV32I encodings and checks decode, operands and ID/EX sequencing

`timescale 1ns/1ps
`include "id_macros.svh"

module tb_id_stage;

  import id_pkg::*;

  // Cycles any single wait may take
  localparam int TIMEOUT = 20;

  logic                clk_i;
  logic                rst_ni;
  logic                run_i;
  logic                instr_valid_i;
  logic [`ID_XLEN-1:0] instr_rdata_i;
  logic [`ID_XLEN-1:0] pc_id_i;
  logic                branch_decision_i;
  logic                ex_valid_i;
  logic                lsu_resp_valid_i;
  logic                lsu_addr_incr_req_i;
  logic [`ID_XLEN-1:0] lsu_addr_last_i;
  logic [`ID_XLEN-1:0] rf_rdata_a_i;
  logic [`ID_XLEN-1:0] rf_rdata_b_i;
  logic [`ID_XLEN-1:0] result_ex_i;
  rf_rd_t              rf_rd_o;
  alu_req_t            alu_req_o;
  lsu_req_t            lsu_req_o;
  rf_wb_t              rf_wb_o;
  logic                pc_set_o;
  logic                illegal_insn_o;
  logic                instr_first_cycle_o;
  logic                instr_done_o;

  int          errors;
  int          test_errors;
  int          checks;
  int          tests;
  int          pc_sets;
  string       test_name;
  logic [31:0] rng_state;

  id_stage id_stage_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Running count of PC sets, sampled mid-cycle
  always @(negedge clk_i) begin
    if (pc_set_o) pc_sets++;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // RV32I encoders, field order taken from the base ISA formats
  function automatic logic [31:0] encode_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] encode_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  // B and J scatter the offset bits, bit 0 is implied
  function automatic logic [31:0] encode_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encode_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Called at a drive point, returns at the sample point of the done cycle
  task automatic wait_done();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!instr_done_o && n < TIMEOUT) begin
      next_cycle();
      @(negedge clk_i);
      n++;
    end
    if (!instr_done_o) begin
      $display("%s: timeout, instr_done_o never rose", test_name);
      errors++;
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests++;
  endtask

  task automatic end_test();
    $display("%-12s finished with %0d errors", test_name, test_errors);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_alu();
    logic [31:0] a, b, res;
    begin_test("alu");
    a = next_random();
    b = next_random();
    res = next_random();
    rf_rdata_a_i  = a;
    rf_rdata_b_i  = b;
    result_ex_i   = res;
    // ADDI x7, x3, -12
    instr_rdata_i = encode_i(12'hff4, 5'd3, 3'b000, 5'd7, 7'h13);
    instr_valid_i = 1'b1;
    @(negedge clk_i);
    compare_value("raddr_a", 3, 32'(rf_rd_o.raddr_a));
    compare_value("addi ren_a", 1, 32'(rf_rd_o.ren_a));
    compare_value("addi ren_b", 0, 32'(rf_rd_o.ren_b));
    compare_value("addi op", 32'(ALU_ADD), 32'(alu_req_o.op));
    compare_value("addi a", a, alu_req_o.operand_a);
    compare_value("addi b", 32'hffff_fff4, alu_req_o.operand_b);
    compare_value("addi we", 1, 32'(rf_wb_o.we));
    compare_value("addi waddr", 7, 32'(rf_wb_o.waddr));
    compare_value("addi wdata", res, rf_wb_o.wdata);
    compare_value("addi done", 1, 32'(instr_done_o));
    compare_value("addi first", 1, 32'(instr_first_cycle_o));
    next_cycle();
    // SUB x12, x4, x9
    instr_rdata_i = encode_r(7'h20, 5'd9, 5'd4, 3'b000, 5'd12);
    @(negedge clk_i);
    compare_value("raddr_a", 4, 32'(rf_rd_o.raddr_a));
    compare_value("raddr_b", 9, 32'(rf_rd_o.raddr_b));
    compare_value("sub ren_a", 1, 32'(rf_rd_o.ren_a));
    compare_value("sub ren_b", 1, 32'(rf_rd_o.ren_b));
    compare_value("sub op", 32'(ALU_SUB), 32'(alu_req_o.op));
    compare_value("sub a", a, alu_req_o.operand_a);
    compare_value("sub b", b, alu_req_o.operand_b);
    compare_value("sub waddr", 12, 32'(rf_wb_o.waddr));
    compare_value("sub done", 1, 32'(instr_done_o));
    next_cycle();
    instr_valid_i = 1'b0;
    end_test();
  endtask

  task automatic test_load_store();
    logic [31:0] a, b, res, last;
    begin_test("load_store");
    a = next_random();
    b = next_random();
    res = next_random();
    last = next_random();
    rf_rdata_a_i  = a;
    rf_rdata_b_i  = b;
    result_ex_i   = res;
    // LW x5, 8(x2), word and signed
    instr_rdata_i = encode_i(12'h008, 5'd2, 3'b010, 5'd5, 7'h03);
    instr_valid_i = 1'b1;
    @(negedge clk_i);
    compare_value("lw req", 1, 32'(lsu_req_o.req));
    compare_value("lw we", 0, 32'(lsu_req_o.we));
    compare_value("lw type", 0, 32'(lsu_req_o.data_type));
    compare_value("lw sign_ext", 1, 32'(lsu_req_o.sign_ext));
    compare_value("lw addr a", a, alu_req_o.operand_a);
    compare_value("lw addr b", 8, alu_req_o.operand_b);
    compare_value("lw early done", 0, 32'(instr_done_o));
    // Response held back, request must not repeat
    for (int i = 0; i < 3; i++) begin
      next_cycle();
      @(negedge clk_i);
      compare_value("lw req again", 0, 32'(lsu_req_o.req));
      compare_value("lw early done", 0, 32'(instr_done_o));
      compare_value("lw first", 0, 32'(instr_first_cycle_o));
    end
    next_cycle();
    lsu_resp_valid_i = 1'b1;
    wait_done();
    compare_value("lw rf we", 1, 32'(rf_wb_o.we));
    compare_value("lw waddr", 5, 32'(rf_wb_o.waddr));
    compare_value("lw wdata", res, rf_wb_o.wdata);
    next_cycle();
    lsu_resp_valid_i = 1'b0;
    // SW x6, -20(x2)
    instr_rdata_i = encode_s(12'hfec, 5'd6, 5'd2, 3'b010);
    @(negedge clk_i);
    compare_value("sw req", 1, 32'(lsu_req_o.req));
    compare_value("sw we", 1, 32'(lsu_req_o.we));
    compare_value("sw type", 0, 32'(lsu_req_o.data_type));
    compare_value("sw sign_ext", 0, 32'(lsu_req_o.sign_ext));
    compare_value("sw wdata", b, lsu_req_o.wdata);
    compare_value("sw addr b", 32'hffff_ffec, alu_req_o.operand_b);
    next_cycle();
    // Second access of a misaligned store
    lsu_addr_incr_req_i = 1'b1;
    lsu_addr_last_i     = last;
    @(negedge clk_i);
    compare_value("incr a", last, alu_req_o.operand_a);
    compare_value("incr b", 4, alu_req_o.operand_b);
    compare_value("incr req", 0, 32'(lsu_req_o.req));
    next_cycle();
    lsu_addr_incr_req_i = 1'b0;
    lsu_resp_valid_i    = 1'b1;
    wait_done();
    compare_value("sw rf we", 0, 32'(rf_wb_o.we));
    next_cycle();
    instr_valid_i    = 1'b0;
    lsu_resp_valid_i = 1'b0;
    end_test();
  endtask

  // Offset -16, target computed in the second cycle when taken
  task automatic run_branch(input logic [2:0] f3, input alu_op_e exp_op, input logic taken);
    logic [31:0] pc;
    int          start;
    pc                = next_random() & 32'hffff_fffc;
    pc_id_i           = pc;
    rf_rdata_a_i      = next_random();
    rf_rdata_b_i      = next_random();
    instr_rdata_i     = encode_b(13'h1ff0, 5'd7, 5'd6, f3);
    branch_decision_i = taken;
    ex_valid_i        = 1'b0;
    instr_valid_i     = 1'b1;
    start             = pc_sets;
    @(negedge clk_i);
    compare_value("cmp op", 32'(exp_op), 32'(alu_req_o.op));
    compare_value("cmp a", rf_rdata_a_i, alu_req_o.operand_a);
    compare_value("cmp b", rf_rdata_b_i, alu_req_o.operand_b);
    compare_value("cmp done", 32'(!taken), 32'(instr_done_o));
    if (taken) begin
      next_cycle();
      branch_decision_i = 1'b0;
      @(negedge clk_i);
      compare_value("pc_set", 1, 32'(pc_set_o));
      compare_value("target a", pc, alu_req_o.operand_a);
      compare_value("target b", 32'hffff_fff0, alu_req_o.operand_b);
      next_cycle();
      ex_valid_i = 1'b1;
      wait_done();
    end
    next_cycle();
    compare_value("pc_set count", 32'(taken), 32'(pc_sets - start));
    instr_valid_i     = 1'b0;
    ex_valid_i        = 1'b0;
    branch_decision_i = 1'b0;
  endtask

  task automatic test_branches();
    begin_test("branch");
    run_branch(3'b000, ALU_EQ, 1'b1);
    run_branch(3'b100, ALU_LT, 1'b1);
    run_branch(3'b000, ALU_EQ, 1'b0);
    end_test();
  endtask

  task automatic test_jal();
    logic [31:0] pc, res;
    int          start;
    begin_test("jal");
    pc            = next_random() & 32'hffff_fffc;
    res           = next_random();
    pc_id_i       = pc;
    result_ex_i   = res;
    ex_valid_i    = 1'b0;
    start         = pc_sets;
    // JAL x1 with a negative offset
    instr_rdata_i = encode_j(21'h100ace, 5'd1);
    instr_valid_i = 1'b1;
    @(negedge clk_i);
    compare_value("jal pc_set", 1, 32'(pc_set_o));
    compare_value("jal a", pc, alu_req_o.operand_a);
    compare_value("jal b", 32'hfff0_0ace, alu_req_o.operand_b);
    compare_value("jal done", 0, 32'(instr_done_o));
    next_cycle();
    @(negedge clk_i);
    compare_value("link a", pc, alu_req_o.operand_a);
    compare_value("link b", 4, alu_req_o.operand_b);
    compare_value("link done", 0, 32'(instr_done_o));
    next_cycle();
    ex_valid_i = 1'b1;
    wait_done();
    compare_value("link we", 1, 32'(rf_wb_o.we));
    compare_value("link waddr", 1, 32'(rf_wb_o.waddr));
    compare_value("link wdata", res, rf_wb_o.wdata);
    next_cycle();
    compare_value("pc_set count", 1, 32'(pc_sets - start));
    instr_valid_i = 1'b0;
    ex_valid_i    = 1'b0;
    end_test();
  endtask

  task automatic test_illegal();
    logic [31:0] words [4];
    logic [31:0] r;
    begin_test("illegal");
    r = next_random();
    // Custom opcode, FENCE, MUL and LD are all outside the kept subset
    words[0] = {r[31:7], 7'h0b};
    words[1] = 32'h0ff0_000f;
    words[2] = encode_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3);
    words[3] = encode_i(12'h004, 5'd1, 3'b011, 5'd2, 7'h03);
    for (int i = 0; i < 4; i++) begin
      instr_rdata_i = words[i];
      instr_valid_i = 1'b1;
      @(negedge clk_i);
      compare_value("illegal flag", 1, 32'(illegal_insn_o));
      compare_value("illegal done", 1, 32'(instr_done_o));
      compare_value("illegal we", 0, 32'(rf_wb_o.we));
      compare_value("illegal req", 0, 32'(lsu_req_o.req));
      next_cycle();
    end
    instr_valid_i = 1'b0;
    end_test();
  endtask

  task automatic test_run_low();
    logic [31:0] words [2];
    begin_test("run_low");
    words[0] = encode_i(12'h010, 5'd8, 3'b010, 5'd9, 7'h03);
    words[1] = encode_j(21'h000040, 5'd1);
    // Both stall sources ready, only run_i holds the stage
    ex_valid_i       = 1'b1;
    lsu_resp_valid_i = 1'b1;
    for (int w = 0; w < 2; w++) begin
      run_i         = 1'b0;
      instr_rdata_i = words[w];
      instr_valid_i = 1'b1;
      for (int i = 0; i < 3; i++) begin
        @(negedge clk_i);
        compare_value("frozen done", 0, 32'(instr_done_o));
        compare_value("frozen req", 0, 32'(lsu_req_o.req));
        compare_value("frozen we", 0, 32'(rf_wb_o.we));
        compare_value("frozen pc_set", 0, 32'(pc_set_o));
        next_cycle();
      end
      run_i = 1'b1;
      @(negedge clk_i);
      compare_value("resumed", 1, 32'(lsu_req_o.req | pc_set_o));
      compare_value("resumed done", 0, 32'(instr_done_o));
      next_cycle();
      wait_done();
      next_cycle();
    end
    instr_valid_i    = 1'b0;
    ex_valid_i       = 1'b0;
    lsu_resp_valid_i = 1'b0;
    end_test();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rng_state           = 32'h4b8af2d0;
    errors              = 0;
    test_errors         = 0;
    checks              = 0;
    tests               = 0;
    pc_sets             = 0;
    rst_ni              = 1'b0;
    run_i               = 1'b1;
    instr_valid_i       = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_resp_valid_i    = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    lsu_addr_last_i     = '0;
    rf_rdata_a_i        = '0;
    rf_rdata_b_i        = '0;
    result_ex_i         = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();
    test_alu();
    test_load_store();
    test_branches();
    test_jal();
    test_illegal();
    test_run_low();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- id_stage.sv
// Instruction decode stage top
// Joins decoder, operand mux and ID/EX sequencer into the port structs

`timescale 1ns/1ps
`include "id_macros.svh"

module id_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                run_i,
  input  logic                instr_valid_i,
  input  logic [`ID_XLEN-1:0] instr_rdata_i,
  input  logic [`ID_XLEN-1:0] pc_id_i,
  input  logic                branch_decision_i,
  input  logic                ex_valid_i,
  input  logic                lsu_resp_valid_i,
  input  logic                lsu_addr_incr_req_i,
  input  logic [`ID_XLEN-1:0] lsu_addr_last_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0] result_ex_i,
  output id_pkg::rf_rd_t      rf_rd_o,
  output id_pkg::alu_req_t    alu_req_o,
  output id_pkg::lsu_req_t    lsu_req_o,
  output id_pkg::rf_wb_t      rf_wb_o,
  output logic                pc_set_o,
  output logic                illegal_insn_o,
  output logic                instr_first_cycle_o,
  output logic                instr_done_o
);

  import id_pkg::*;

  dec_ctrl_t ctrl;
  imm_set_t  imm;
  logic      first_cycle;
  logic      lsu_req;
  logic      rf_we;

  id_decoder id_decoder_inst (
    .instr_rdata_i      (instr_rdata_i),
    .instr_first_cycle_i(first_cycle),
    .ctrl_o             (ctrl),
    .imm_o              (imm),
    .rf_rd_o            (rf_rd_o)
  );

  id_operand_mux id_operand_mux_inst (
    .ctrl_i             (ctrl),
    .imm_i              (imm),
    .rf_rdata_a_i       (rf_rdata_a_i),
    .rf_rdata_b_i       (rf_rdata_b_i),
    .pc_id_i            (pc_id_i),
    .lsu_addr_incr_req_i(lsu_addr_incr_req_i),
    .lsu_addr_last_i    (lsu_addr_last_i),
    .operand_a_o        (alu_req_o.operand_a),
    .operand_b_o        (alu_req_o.operand_b)
  );

  id_ex_fsm id_ex_fsm_inst (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .run_i              (run_i),
    .ctrl_i             (ctrl),
    .branch_decision_i  (branch_decision_i),
    .ex_valid_i         (ex_valid_i),
    .lsu_resp_valid_i   (lsu_resp_valid_i),
    .instr_first_cycle_o(first_cycle),
    .instr_done_o       (instr_done_o),
    .lsu_req_o          (lsu_req),
    .rf_we_o            (rf_we),
    .pc_set_o           (pc_set_o)
  );

  assign alu_req_o.op = ctrl.alu_op;

  // Store data comes straight from the register file
  assign lsu_req_o.req       = lsu_req;
  assign lsu_req_o.we        = ctrl.lsu_we;
  assign lsu_req_o.data_type = ctrl.lsu_type;
  assign lsu_req_o.sign_ext  = ctrl.lsu_sign_ext;
  assign lsu_req_o.wdata     = rf_rdata_b_i;

  // EX result is the only write source
  assign rf_wb_o.we    = rf_we;
  assign rf_wb_o.waddr = ctrl.rf_waddr;
  assign rf_wb_o.wdata = result_ex_i;

  assign illegal_insn_o      = instr_valid_i & ctrl.illegal;
  assign instr_first_cycle_o = first_cycle;

endmodule

//--- id_ex_fsm.sv
// ID/EX sequencer
// Tracks first and multi cycle, derives stalls, gates requests and writes

`timescale 1ns/1ps

module id_ex_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_valid_i,
  input  logic              run_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  logic              branch_decision_i,
  input  logic              ex_valid_i,
  input  logic              lsu_resp_valid_i,
  output logic              instr_first_cycle_o,
  output logic              instr_done_o,
  output logic              lsu_req_o,
  output logic              rf_we_o,
  output logic              pc_set_o
);

  import id_pkg::*;

  id_fsm_e fsm_q, fsm_d;
  logic    executing;
  logic    first_cycle;
  logic    multicycle_done;
  logic    stall_mem, stall_branch, stall_jump;
  logic    branch_set_d, branch_set_q;
  logic    jump_set_raw;
  logic    set_raw;
  logic    set_done_q;

  // No writeback stage, a valid instruction executes whenever the core runs
  assign executing   = instr_valid_i & run_i;
  assign first_cycle = instr_valid_i & (fsm_q == FIRST_CYCLE);

  // Memory ops end on the response, branches and jumps on EX valid
  assign multicycle_done = ctrl_i.lsu_req ? lsu_resp_valid_i : ex_valid_i;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    fsm_d        = fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_raw = 1'b0;
    if (executing) begin
      unique case (fsm_q)
        FIRST_CYCLE: begin
          if (ctrl_i.lsu_req) begin
            fsm_d = MULTI_CYCLE;
          end else if (ctrl_i.branch) begin
            // Taken branch computes its target in the next cycle
            fsm_d        = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl_i.jump) begin
            fsm_d        = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        default: begin
          if (multicycle_done) begin
            fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = ctrl_i.branch;
            stall_jump   = ctrl_i.jump;
          end
        end
      endcase
    end
  end

  // Loads and stores always hold the first cycle, then wait for the response
  assign stall_mem = instr_valid_i & ctrl_i.lsu_req & (~lsu_resp_valid_i | first_cycle);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q        <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
    end else if (executing) begin
      fsm_q        <= fsm_d;
      branch_set_q <= branch_set_d;
    end
  end

  ////////////////////////////////////////
  // PC set and completion
  ////////////////////////////////////////

  assign set_raw = (branch_set_q & executing) | jump_set_raw;

  // Remembers a set already issued, so one instruction sets the PC once
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_done_q <= 1'b0;
    end else begin
      set_done_q <= (set_raw | set_done_q) & ~instr_done_o;
    end
  end

  assign pc_set_o = set_raw & ~set_done_q;

  assign instr_done_o        = executing & ~(stall_mem | stall_branch | stall_jump);
  assign instr_first_cycle_o = first_cycle;

  // Request only once per instruction, write only on completion
  assign lsu_req_o = executing & first_cycle & ctrl_i.lsu_req;
  assign rf_we_o   = instr_done_o & ctrl_i.rf_we;

endmodule

//--- id_operand_mux.sv
// ALU operand selection
// Register, PC or zero on A, register or immediate on B, misaligned override

`timescale 1ns/1ps
`include "id_macros.svh"

module id_operand_mux (
  input  id_pkg::dec_ctrl_t   ctrl_i,
  input  id_pkg::imm_set_t    imm_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
  input  logic [`ID_XLEN-1:0] pc_id_i,
  input  logic                lsu_addr_incr_req_i,
  input  logic [`ID_XLEN-1:0] lsu_addr_last_i,
  output logic [`ID_XLEN-1:0] operand_a_o,
  output logic [`ID_XLEN-1:0] operand_b_o
);

  import id_pkg::*;

  op_a_sel_e           op_a_sel;
  op_b_sel_e           op_b_sel;
  imm_b_sel_e          imm_b_sel;
  logic [`ID_XLEN-1:0] imm_b;

  // Second half of a misaligned access computes last address plus 4
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : ctrl_i.op_a_sel;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : ctrl_i.op_b_sel;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : ctrl_i.imm_b_sel;

  always_comb begin
    unique case (op_a_sel)
      OP_A_REG_A:  operand_a_o = rf_rdata_a_i;
      OP_A_FWD:    operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: operand_a_o = pc_id_i;
      default:     operand_a_o = '0;
    endcase
  end

  always_comb begin
    unique case (imm_b_sel)
      IMM_B_I:       imm_b = imm_i.i;
      IMM_B_S:       imm_b = imm_i.s;
      IMM_B_B:       imm_b = imm_i.b;
      IMM_B_U:       imm_b = imm_i.u;
      IMM_B_J:       imm_b = imm_i.j;
      IMM_B_INCR_PC: imm_b = `ID_XLEN'(`ID_INCR_PC);
      default:       imm_b = `ID_XLEN'(`ID_INCR_ADDR);
    endcase
  end

  assign operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

//--- id_decoder.sv
// RV32I instruction decoder
// Produces ALU control, operand selects, memory control and immediates

`timescale 1ns/1ps
`include "id_macros.svh"

module id_decoder (
  input  logic [`ID_XLEN-1:0] instr_rdata_i,
  input  logic                instr_first_cycle_i,
  output id_pkg::dec_ctrl_t   ctrl_o,
  output id_pkg::imm_set_t    imm_o,
  output id_pkg::rf_rd_t      rf_rd_o
);

  import id_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       ren_a;
  logic       ren_b;

  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  assign imm_o.i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_o.s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  // B and J immediates are scrambled, bit 0 always zero
  assign imm_o.b = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                    instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_o.u = {instr_rdata_i[31:12], 12'b0};
  assign imm_o.j = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                    instr_rdata_i[30:21], 1'b0};

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////

  always_comb begin
    // Defaults describe a register plus I-immediate add with no side effects
    ctrl_o           = '0;
    ctrl_o.alu_op    = ALU_ADD;
    ctrl_o.op_a_sel  = OP_A_REG_A;
    ctrl_o.op_b_sel  = OP_B_IMM;
    ctrl_o.imm_b_sel = IMM_B_I;
    ctrl_o.rf_waddr  = instr_rdata_i[11:7];
    ren_a            = 1'b0;
    ren_b            = 1'b0;

    unique case (opcode_e'(instr_rdata_i[6:0]))
      OPCODE_LUI: begin
        ctrl_o.op_a_sel  = OP_A_ZERO;
        ctrl_o.imm_b_sel = IMM_B_U;
        ctrl_o.rf_we     = 1'b1;
      end
      OPCODE_AUIPC: begin
        ctrl_o.op_a_sel  = OP_A_CURRPC;
        ctrl_o.imm_b_sel = IMM_B_U;
        ctrl_o.rf_we     = 1'b1;
      end
      OPCODE_OP_IMM: begin
        ren_a        = 1'b1;
        ctrl_o.rf_we = 1'b1;
        unique case (funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b110: ctrl_o.alu_op = ALU_OR;
          3'b111: ctrl_o.alu_op = ALU_AND;
          3'b001: begin
            ctrl_o.alu_op  = ALU_SLL;
            ctrl_o.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            ctrl_o.alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
            ctrl_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      OPCODE_OP: begin
        ren_a           = 1'b1;
        ren_b           = 1'b1;
        ctrl_o.op_b_sel = OP_B_REG_B;
        ctrl_o.rf_we    = 1'b1;
        unique case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
          {7'b0000000, 3'b001}: ctrl_o.alu_op = ALU_SLL;
          {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
          {7'b0000000, 3'b011}: ctrl_o.alu_op = ALU_SLTU;
          {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
          {7'b0000000, 3'b101}: ctrl_o.alu_op = ALU_SRL;
          {7'b0100000, 3'b101}: ctrl_o.alu_op = ALU_SRA;
          {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
          default:              ctrl_o.illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        ren_a               = 1'b1;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.lsu_req      = 1'b1;
        // funct3[2] marks the unsigned byte and half loads
        ctrl_o.lsu_sign_ext = ~funct3[2];
        unique case (funct3)
          3'b000, 3'b100: ctrl_o.lsu_type = 2'b10;
          3'b001, 3'b101: ctrl_o.lsu_type = 2'b01;
          3'b010:         ctrl_o.lsu_type = 2'b00;
          default:        ctrl_o.illegal  = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        ren_a            = 1'b1;
        ren_b            = 1'b1;
        ctrl_o.imm_b_sel = IMM_B_S;
        ctrl_o.lsu_req   = 1'b1;
        ctrl_o.lsu_we    = 1'b1;
        unique case (funct3)
          3'b000:  ctrl_o.lsu_type = 2'b10;
          3'b001:  ctrl_o.lsu_type = 2'b01;
          3'b010:  ctrl_o.lsu_type = 2'b00;
          default: ctrl_o.illegal  = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        ren_a         = 1'b1;
        ren_b         = 1'b1;
        ctrl_o.branch = 1'b1;
        unique case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
        if (instr_first_cycle_i) begin
          // Compare rs1 against rs2
          ctrl_o.op_b_sel = OP_B_REG_B;
        end else begin
          // Target address PC plus B-immediate
          ctrl_o.alu_op    = ALU_ADD;
          ctrl_o.op_a_sel  = OP_A_CURRPC;
          ctrl_o.imm_b_sel = IMM_B_B;
        end
      end
      OPCODE_JAL: begin
        ctrl_o.jump     = 1'b1;
        ctrl_o.op_a_sel = OP_A_CURRPC;
        if (instr_first_cycle_i) begin
          ctrl_o.imm_b_sel = IMM_B_J;
        end else begin
          // Link value PC plus 4 goes to rd
          ctrl_o.imm_b_sel = IMM_B_INCR_PC;
          ctrl_o.rf_we     = 1'b1;
        end
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal encodings must have no side effects
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we   = 1'b0;
      ctrl_o.lsu_req = 1'b0;
      ctrl_o.branch  = 1'b0;
      ctrl_o.jump    = 1'b0;
      ren_a          = 1'b0;
      ren_b          = 1'b0;
    end
  end

  assign rf_rd_o.raddr_a = instr_rdata_i[19:15];
  assign rf_rd_o.raddr_b = instr_rdata_i[24:20];
  assign rf_rd_o.ren_a   = ren_a;
  assign rf_rd_o.ren_b   = ren_b;

endmodule

//--- id_pkg.sv
// Decode stage types
// Opcodes, ALU operations, operand selectors and the port structs

`include "id_macros.svh"

package id_pkg;

  // RV32I major opcodes handled by the stage
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // Arithmetic, logic, shift and comparison operations
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_FWD, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC, IMM_B_INCR_ADDR
  } imm_b_sel_e;

  // Sign-extended immediates of all formats
  typedef struct packed {
    logic [`ID_XLEN-1:0] i;
    logic [`ID_XLEN-1:0] s;
    logic [`ID_XLEN-1:0] b;
    logic [`ID_XLEN-1:0] u;
    logic [`ID_XLEN-1:0] j;
  } imm_set_t;

  // Decoded control of one instruction
  typedef struct packed {
    logic                  illegal;
    alu_op_e               alu_op;
    op_a_sel_e             op_a_sel;
    op_b_sel_e             op_b_sel;
    imm_b_sel_e            imm_b_sel;
    logic                  rf_we;
    logic [`ID_REG_AW-1:0] rf_waddr;
    logic                  lsu_req;
    logic                  lsu_we;
    logic [1:0]            lsu_type;
    logic                  lsu_sign_ext;
    logic                  branch;
    logic                  jump;
  } dec_ctrl_t;

  typedef struct packed {
    logic [`ID_REG_AW-1:0] raddr_a;
    logic [`ID_REG_AW-1:0] raddr_b;
    logic                  ren_a;
    logic                  ren_b;
  } rf_rd_t;

  typedef struct packed {
    alu_op_e             op;
    logic [`ID_XLEN-1:0] operand_a;
    logic [`ID_XLEN-1:0] operand_b;
  } alu_req_t;

  // Memory request, data_type is 00 word, 01 half, 10 byte
  typedef struct packed {
    logic                req;
    logic                we;
    logic [1:0]          data_type;
    logic                sign_ext;
    logic [`ID_XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                  we;
    logic [`ID_REG_AW-1:0] waddr;
    logic [`ID_XLEN-1:0]   wdata;
  } rf_wb_t;

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

endpackage

//--- id_macros.svh
// Decode stage widths and constants
// Shared by the package and every RTL block of the stage

`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Data path width
`define ID_XLEN 32

// Register file address width
`define ID_REG_AW 5

// Offset of the second access of a misaligned load or store
`define ID_INCR_ADDR 4

// Link offset for JAL, no compressed instructions
`define ID_INCR_PC 4

`endif
